/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP        = tb_gf3m_mult
FILELIST   = vlog.f
LOG        = sim.log
FAIL_MSG   = Simulation failed

SHELL := /bin/bash

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	set -o pipefail; ./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

/* gf3_pkg.sv */
`default_nettype none

package gf3_pkg;

    // GF(3^97) reduced by the trinomial x^97 + x^12 + 2
    localparam int gf_m   = 97;         // field degree
    localparam int gf_tap = 12;         // middle term of the trinomial
    localparam int gf_w   = 2 * gf_m;   // two bits per trit

    // trit code: 00 is 0, 01 is 1, 10 is 2, 11 unused
    typedef logic [1:0] trit_t;

    localparam trit_t trit_zero = 2'b00;
    localparam trit_t trit_one  = 2'b01;
    localparam trit_t trit_two  = 2'b10;

    // one element read as a flat word or as trits, trit 0 in the low bits
    typedef union packed
    {
        logic [gf_w-1:0]  bits;
        trit_t [gf_m-1:0] trits;
    } gf_elem_t;

    // sum mod 3
    function automatic trit_t trit_add(input trit_t a, input trit_t b);
        logic [2:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= 3'd3)
        begin
            s = s - 3'd3;
        end
        return s[1:0];
    endfunction

    // product mod 3
    function automatic trit_t trit_mul(input trit_t a, input trit_t b);
        if (a == trit_zero || b == trit_zero)
        begin
            return trit_zero;
        end
        else if (a == b)
        begin
            return trit_one;                // 1*1 and 2*2
        end
        else
        begin
            return trit_two;
        end
    endfunction

    // 1 and 2 trade places, 0 stays 0
    function automatic trit_t trit_neg(input trit_t t);
        return {t[0], t[1]};
    endfunction

endpackage

`default_nettype wire

/* gf3m_digit_mac.sv */
`timescale 1ns/100ps
`default_nettype none

module gf3m_digit_mac
#(
    parameter int DIGITS = 3                        // trits in one digit
)
(
    input  gf3_pkg::gf_elem_t           x,
    input  gf3_pkg::trit_t [DIGITS-1:0] digit,
    input  gf3_pkg::gf_elem_t           acc,
    output gf3_pkg::gf_elem_t           sum
);
    import gf3_pkg::*;

    localparam int wide_n = gf_m + DIGITS - 1;      // trits of x * digit before reduction

    trit_t [wide_n-1:0] wide;

    genvar k;

    // schoolbook product, one column per exponent
    generate
        for (k = 0; k < wide_n; k++)
        begin : g_prod
            localparam int j_lo = (k >= gf_m) ? k - gf_m + 1 : 0;
            localparam int j_hi = (k < DIGITS) ? k : DIGITS - 1;

            trit_t col;

            always_comb
            begin
                col = trit_zero;
                for (int j = j_lo; j <= j_hi; j++)
                begin
                    col = trit_add(col, trit_mul(x.trits[k - j], digit[j]));
                end
            end

            assign wide[k] = col;
        end
    endgenerate

    // x^(97+r) folds to x^r - x^(12+r), then acc is added
    generate
        for (k = 0; k < gf_m; k++)
        begin : g_fold
            trit_t wrap;
            trit_t tap;

            if (k < DIGITS - 1)
            begin : g_wrap
                assign wrap = wide[gf_m + k];
            end
            else
            begin : g_no_wrap
                assign wrap = trit_zero;
            end

            if (k >= gf_tap && k < gf_tap + DIGITS - 1)
            begin : g_tap
                assign tap = trit_neg(wide[gf_m + k - gf_tap]);
            end
            else
            begin : g_no_tap
                assign tap = trit_zero;
            end

            assign sum.trits[k] = trit_add(trit_add(wide[k], wrap), trit_add(tap, acc.trits[k]));
        end
    endgenerate

endmodule

`default_nettype wire

/* gf3m_mult.sv */
`timescale 1ns/100ps
`default_nettype none

module gf3m_mult
#(
    parameter int DIGITS = 3                        // trits of b consumed per cycle
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  gf3_pkg::gf_elem_t a,
    input  gf3_pkg::gf_elem_t b,
    output gf3_pkg::gf_elem_t c,
    output logic              done
);

    logic step;
    logic last;

    gf3m_mult_ctrl
    #(
        .DIGITS (DIGITS)
    )
    ctrl_inst
    (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .step  (step),
        .last  (last),
        .done  (done)
    );

    gf3m_mult_datapath
    #(
        .DIGITS (DIGITS)
    )
    datapath_inst
    (
        .clk   (clk),
        .start (start),
        .step  (step),
        .last  (last),
        .a     (a),
        .b     (b),
        .c     (c)
    );

endmodule

`default_nettype wire

/* gf3m_mult_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module gf3m_mult_assert
#(
    parameter int DIGITS = 3
)
(
    input logic              clk,
    input logic              reset,
    input logic              start,
    input logic              done,
    input gf3_pkg::gf_elem_t a,
    input gf3_pkg::gf_elem_t b,
    input gf3_pkg::gf_elem_t c
);
    import gf3_pkg::*;

    // one edge per digit of b, one more to write c
    localparam int latency = (gf_m + DIGITS - 1) / DIGITS + 1;

    gf_elem_t expected;

    // horner form: r = r * x + b_i * a, highest trit of b first
    function automatic gf_elem_t model(input gf_elem_t p, input gf_elem_t q);
        int       r [gf_m];
        int       top;
        gf_elem_t res;
        for (int k = 0; k < gf_m; k++)
        begin
            r[k] = 0;
        end
        for (int i = gf_m - 1; i >= 0; i--)
        begin
            top = r[gf_m-1];
            for (int k = gf_m - 1; k > 0; k--)
            begin
                r[k] = r[k-1];
            end
            r[0]      = top;                        // x^97 = 1 - x^12
            r[gf_tap] = r[gf_tap] + 2 * top;
            for (int k = 0; k < gf_m; k++)
            begin
                r[k] = (r[k] + int'(p.trits[k]) * int'(q.trits[i])) % 3;
            end
        end
        for (int k = 0; k < gf_m; k++)
        begin
            res.trits[k] = trit_t'(r[k]);
        end
        return res;
    endfunction

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            expected <= model(a, b);
        end
    end

    a_done_clear: assert property (@(posedge clk) disable iff (reset) start |=> !done)
        else $error("done high on the edge after start");

    a_done_time: assert property (@(posedge clk) disable iff (reset)
        $rose(done) |-> $past(start, latency + 1))
        else $error("done rose at the wrong distance from start");

    a_done_hold: assert property (@(posedge clk) disable iff (reset)
        done && !start |=> done && $stable(c))
        else $error("done or c changed without a start");

    a_c_value: assert property (@(posedge clk) disable iff (reset) done |-> c == expected)
        else $error("c differs from the product of the last operands");

endmodule

bind gf3m_mult gf3m_mult_assert
#(
    .DIGITS (DIGITS)
)
assert_inst
(
    .clk   (clk),
    .reset (reset),
    .start (start),
    .done  (done),
    .a     (a),
    .b     (b),
    .c     (c)
);

`default_nettype wire

/* gf3m_mult_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module gf3m_mult_ctrl
#(
    parameter int DIGITS = 3                        // trits of b per step
)
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic step,
    output logic last,
    output logic done
);
    import gf3_pkg::*;

    localparam int steps  = (gf_m + DIGITS - 1) / DIGITS;   // digits in b
    // one more cycle takes a zero digit and writes c
    localparam int cycles = steps + 1;
    localparam int cnt_w  = $clog2(cycles + 1);

    logic [cnt_w-1:0] cnt;                          // cycles left

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cnt <= '0;
        end
        else if (start)
        begin
            cnt <= cnt_w'(cycles);                  // restart even when busy
        end
        else if (step)
        begin
            cnt <= cnt - 1'b1;
        end
    end

    assign step = (cnt != '0);
    assign last = (cnt == cnt_w'(1));

    always_ff @(posedge clk)
    begin
        if (reset || start)
        begin
            done <= 1'b0;
        end
        else if (last)
        begin
            done <= 1'b1;                           // holds until the next start
        end
    end

endmodule

`default_nettype wire

/* gf3m_mult_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module gf3m_mult_datapath
#(
    parameter int DIGITS = 3                        // trits of b per step
)
(
    input  logic              clk,
    input  logic              start,
    input  logic              step,
    input  logic              last,
    input  gf3_pkg::gf_elem_t a,
    input  gf3_pkg::gf_elem_t b,
    output gf3_pkg::gf_elem_t c
);
    import gf3_pkg::*;

    gf_elem_t x;                                    // a * x^(DIGITS*n)
    gf_elem_t y;                                    // digits of b still to go
    gf_elem_t z;                                    // partial product
    gf_elem_t x_next;
    gf_elem_t z_next;

    // z + x * low digit of y
    gf3m_digit_mac
    #(
        .DIGITS (DIGITS)
    )
    mac_inst
    (
        .x     (x),
        .digit (y.trits[DIGITS-1:0]),
        .acc   (z),
        .sum   (z_next)
    );

    // x * x^DIGITS
    gf3m_shift_reduce
    #(
        .DIGITS (DIGITS)
    )
    shift_inst
    (
        .x (x),
        .y (x_next)
    );

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            x <= a;
            y <= b;
            z <= '0;
        end
        else if (step)
        begin
            x      <= x_next;
            y.bits <= y.bits >> (2 * DIGITS);       // next digit into the low trits
            z      <= z_next;
        end
    end

    // result register, written once per product
    always_ff @(posedge clk)
    begin
        if (last && !start)                         // an aborted run writes nothing
        begin
            c <= z_next;
        end
    end

endmodule

`default_nettype wire

/* gf3m_shift_reduce.sv */
`timescale 1ns/100ps
`default_nettype none

module gf3m_shift_reduce
#(
    parameter int DIGITS = 3                        // exponent of the shift
)
(
    input  gf3_pkg::gf_elem_t x,
    output gf3_pkg::gf_elem_t y
);
    import gf3_pkg::*;

    localparam int top = gf_m - DIGITS;             // first trit that leaves the field

    genvar k;

    // y = x * x^DIGITS mod (x^97 + x^12 + 2)
    generate
        for (k = 0; k < gf_m; k++)
        begin : g_trit
            if (k < DIGITS)
            begin : g_wrap
                assign y.trits[k] = x.trits[top + k];       // x^97 -> 1
            end
            else if (k >= gf_tap && k < gf_tap + DIGITS)
            begin : g_tap
                // x^97 -> -x^12 lands on the shifted trit
                assign y.trits[k] = trit_add(x.trits[k - DIGITS],
                                             trit_neg(x.trits[top + k - gf_tap]));
            end
            else
            begin : g_move
                assign y.trits[k] = x.trits[k - DIGITS];
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* tb_gf3m_mult.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_gf3m_mult;
    import gf3_pkg::*;

    localparam int DIGITS  = 3;
    localparam int latency = 34;                    // start edge to done edge
    localparam int limit   = 200;                   // wait bound in cycles

    logic        clk;
    logic        reset;
    logic        start;
    gf_elem_t    a;
    gf_elem_t    b;
    gf_elem_t    c;
    logic        done;
    logic [31:0] lfsr;
    int          tests;
    int          failed;
    int          errors;
    int          mark;                              // errors before the current test

    gf3m_mult
    #(
        .DIGITS (DIGITS)
    )
    gf3m_mult_inst
    (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .a     (a),
        .b     (b),
        .c     (c),
        .done  (done)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    // galois form, one step per bit taken
    function automatic logic lfsr_bit();
        logic bit0;
        bit0 = lfsr[0];
        lfsr = lfsr >> 1;
        if (bit0)
        begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return bit0;
    endfunction

    function automatic gf_elem_t random_elem();
        gf_elem_t   e;
        logic [1:0] t;
        for (int i = 0; i < gf_m; i++)
        begin
            t[0] = lfsr_bit();
            t[1] = lfsr_bit();
            e.trits[i] = (t == 2'b11) ? 2'b00 : t;  // code 11 is never driven
        end
        return e;
    endfunction

    // schoolbook product, then x^e -> x^(e-97) - x^(e-85) from the top down
    function automatic gf_elem_t ref_mult(input gf_elem_t p, input gf_elem_t q);
        int       prod [2*gf_m-1];
        gf_elem_t r;
        for (int i = 0; i < 2*gf_m-1; i++)
        begin
            prod[i] = 0;
        end
        for (int i = 0; i < gf_m; i++)
        begin
            for (int j = 0; j < gf_m; j++)
            begin
                prod[i+j] += int'(p.trits[i]) * int'(q.trits[j]);
            end
        end
        for (int e = 2*gf_m-2; e >= gf_m; e--)
        begin
            prod[e-gf_m]        += prod[e] % 3;
            prod[e-gf_m+gf_tap] += 2 * (prod[e] % 3);   // minus one is two mod 3
        end
        for (int i = 0; i < gf_m; i++)
        begin
            r.trits[i] = trit_t'(prod[i] % 3);
        end
        return r;
    endfunction

    task automatic launch(input gf_elem_t x, input gf_elem_t y);
        @(negedge clk);
        a     = x;
        b     = y;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // one product from start to done, then compare c
    task automatic multiply(input gf_elem_t x, input gf_elem_t y, input gf_elem_t exp_c);
        int n;
        n = 0;
        launch(x, y);
        assert (!done)
        else
        begin
            $display("done still high on the edge after start");
            errors++;
        end
        while (!done && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!done)
        begin
            $display("timeout: done did not rise within %0d cycles", limit);
            errors++;
        end
        else
        begin
            assert (n == latency)
            else
            begin
                $display("done rose %0d cycles after start, expected %0d", n, latency);
                errors++;
            end
            assert (c === exp_c)
            else
            begin
                $display("CHECK FAILED c: got %h expected %h (a %h, b %h)",
                         c.bits, exp_c.bits, x.bits, y.bits);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == mark)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            failed++;
            $display("test %s: %0d errors", name, errors - mark);
        end
    endtask

    initial
    begin : main
        gf_elem_t x;
        gf_elem_t y;
        gf_elem_t exp_c;

        reset  = 1'b1;
        start  = 1'b0;
        a      = '0;
        b      = '0;
        lfsr   = 32'ha4d0;
        tests  = 0;
        failed = 0;
        errors = 0;
        repeat (16)
        begin
            @(negedge clk);
        end
        reset = 1'b0;

        mark = errors;
        repeat (20)
        begin
            @(negedge clk);
            assert (!done)
            else
            begin
                $display("done rose without a start");
                errors++;
            end
        end
        end_test("reset idle");

        mark = errors;
        x = random_elem();
        y = random_elem();
        exp_c = ref_mult(x, y);
        multiply(x, y, exp_c);
        repeat (10)
        begin
            @(negedge clk);
            assert (done)
            else
            begin
                $display("done fell before the next start");
                errors++;
            end
            assert (c === exp_c)
            else
            begin
                $display("CHECK FAILED c: got %h expected %h while holding",
                         c.bits, exp_c.bits);
                errors++;
            end
        end
        end_test("latency and hold");

        mark = errors;
        for (int i = 0; i < 20; i++)
        begin
            x = random_elem();
            y = random_elem();
            multiply(x, y, ref_mult(x, y));
        end
        end_test("random operands");

        mark = errors;
        x = random_elem();
        y = '0;
        y.trits[0] = 2'b01;
        multiply(x, y, x);                          // a * 1
        multiply(x, '0, '0);                        // a * 0
        end_test("identities");

        mark = errors;
        x = '0;
        x.trits[gf_m-1] = 2'b01;
        y = '0;
        y.trits[1] = 2'b01;
        exp_c = '0;
        exp_c.trits[0]      = 2'b01;                // x^97 = 1 + 2 x^12
        exp_c.trits[gf_tap] = 2'b10;
        multiply(x, y, exp_c);
        end_test("reduction");

        mark = errors;
        launch(random_elem(), random_elem());
        repeat (10) @(negedge clk);
        x = random_elem();
        y = random_elem();
        multiply(x, y, ref_mult(x, y));
        end_test("restart");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
gf3_pkg.sv
gf3m_digit_mac.sv
gf3m_shift_reduce.sv
gf3m_mult_datapath.sv
gf3m_mult_ctrl.sv
gf3m_mult.sv
gf3m_mult_assert.sv
tb_gf3m_mult.sv
